//--- rtl/cam_pkg.sv
package cam_pkg;

  //======================================================================
  // camera byte and pixel types
  //======================================================================

  typedef logic [7:0] cam_byte_t;  // one OV5640 data byte

  // pixel after field reorder, r on top
  typedef struct packed {
    logic [4:0] r;  // red, from raw bits 4:0
    logic [5:0] g;  // green, raw bits 10:5 kept
    logic [4:0] b;  // blue, from raw bits 15:11
  } rgb565_t;

  // one FIFO entry, pixel plus frame markers
  typedef struct packed {
    rgb565_t pixel;  // reordered pixel
    logic    sof;    // first pixel of frame
    logic    eol;    // last pixel of line
  } pix_word_t;

  //======================================================================
  // FIFO sizing
  //======================================================================

  localparam int FIFO_DEPTH = 16;  // entries
  localparam int FIFO_AW    = 4;   // pointer width, log2 of depth
  localparam int FIFO_AFULL = 14;  // writes refused at or above this fill

  //======================================================================
  // frame statistics
  //======================================================================

  // 640x480 = 307200 fits with room to spare
  localparam int FRAME_CNT_W = 20;

endpackage

//--- rtl/pix_stream_if.sv
interface pix_stream_if;
  import cam_pkg::*;

  logic    pix_valid;  // one-cycle strobe, one pixel per strobe
  rgb565_t pix;        // reordered pixel
  logic    pix_sof;    // first pixel after vsync fell
  logic    pix_eol;    // href dropped right after this pixel

  // assembler side
  modport source (
    output pix_valid, pix, pix_sof, pix_eol
  );

  // fifo side, no ready so no back-pressure
  modport sink (
    input pix_valid, pix, pix_sof, pix_eol
  );

  // statistics only need the strobe
  modport monitor (
    input pix_valid
  );

endinterface

//--- rtl/cam_pixel_assembler.sv
module cam_pixel_assembler (
  input  logic               cmos_pclk,  // camera pixel clock
  input  logic               I_rst_n,    // async reset, active low
  input  logic               vsync_i,    // high = frame blanking
  input  logic               href_i,     // byte valid
  input  cam_pkg::cam_byte_t db_i,       // camera data byte
  pix_stream_if.source       pix_o       // assembled pixel stream
);
  import cam_pkg::*;

  cam_byte_t hi_byte;    // first byte of the pair, raw high byte
  logic      phase;      // 1 = next byte closes the pair
  logic      sof_pend;   // next pixel opens a frame
  logic      pair_done;  // second byte sampled this edge
  rgb565_t   pix_next;   // reordered pixel from the pair

  assign pair_done = href_i & phase;

  //======================================================================
  // field reorder, raw {hi_byte, db_i}
  //======================================================================
  always_comb begin
    pix_next.r = db_i[4:0];                  // low five go to the top
    pix_next.g = {hi_byte[2:0], db_i[7:5]};  // middle six stay put
    pix_next.b = hi_byte[7:3];               // top five go to the bottom
  end

  //======================================================================
  // pairing and frame start tracking
  //======================================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      phase           <= 1'b0;
      sof_pend        <= 1'b0;
      pix_o.pix_valid <= 1'b0;
      pix_o.pix_sof   <= 1'b0;
    end else begin
      pix_o.pix_valid <= pair_done;             // 1 cycle after 2nd byte
      pix_o.pix_sof   <= pair_done & sof_pend;
      if (!href_i) begin
        phase <= 1'b0;                          // open pair dropped, restart
      end else begin
        phase <= ~phase;
      end
      if (vsync_i) begin
        sof_pend <= 1'b1;                       // armed through blanking
      end else if (pair_done) begin
        sof_pend <= 1'b0;                       // first pixel consumed it
      end
    end
  end

  // payload, no reset
  always_ff @(posedge cmos_pclk) begin
    if (href_i && !phase) begin
      hi_byte <= db_i;
    end
    if (pair_done) begin
      pix_o.pix <= pix_next;
    end
  end

  // href already low at the edge after the 2nd byte -> line ended
  assign pix_o.pix_eol = pix_o.pix_valid & ~href_i;

endmodule

//--- rtl/cam_pixel_fifo.sv
module cam_pixel_fifo (
  input  logic               cmos_pclk,   // camera pixel clock
  input  logic               I_rst_n,     // async reset, active low
  pix_stream_if.sink         pix_i,       // pixels from the assembler
  output logic               drop_o,      // pixel refused this cycle
  input  logic               rd_en_i,     // read strobe
  output logic               rd_valid_o,  // read data valid, 1 cycle after strobe
  output cam_pkg::pix_word_t rd_word_o,   // oldest entry
  output logic               empty_o      // no entries stored
);
  import cam_pkg::*;

  pix_word_t          mem [FIFO_DEPTH];  // storage array
  logic [FIFO_AW-1:0] wr_ptr;            // next slot to write
  logic [FIFO_AW-1:0] rd_ptr;            // oldest slot
  logic [FIFO_AW:0]   fill_cnt;          // occupancy, 0..FIFO_DEPTH
  logic               wr_ok;             // accepted write
  logic               rd_ok;             // accepted read
  pix_word_t          wr_word;           // packed incoming entry

  //======================================================================
  // write gating and read acceptance
  //======================================================================

  assign wr_word = '{pixel: pix_i.pix, sof: pix_i.pix_sof, eol: pix_i.pix_eol};

  // camera cannot stall, so stop writing at the almost-full level
  assign wr_ok  = pix_i.pix_valid & (fill_cnt < (FIFO_AW + 1)'(FIFO_AFULL));
  assign drop_o = pix_i.pix_valid & ~wr_ok;  // same cycle as refused pixel

  assign empty_o = (fill_cnt == '0);
  assign rd_ok   = rd_en_i & ~empty_o;  // strobe on empty is ignored

  //======================================================================
  // pointers and occupancy
  //======================================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_cnt   <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_ok;
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;  // none, or both at once
      endcase
    end
  end

  //======================================================================
  // storage and registered read data
  //======================================================================
  always_ff @(posedge cmos_pclk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_word;
    end
    if (rd_ok) begin
      rd_word_o <= mem[rd_ptr];  // never the slot being written, fifo not empty
    end
  end

endmodule

//--- rtl/cam_frame_monitor.sv
module cam_frame_monitor (
  input  logic                            cmos_pclk,       // camera pixel clock
  input  logic                            I_rst_n,         // async reset, active low
  input  logic                            vsync_i,         // high = frame blanking
  pix_stream_if.monitor                   pix_i,           // pixel strobe
  input  logic                            drop_i,          // fifo refused the pixel
  output logic                            frame_done_o,    // one-cycle report strobe
  output logic [cam_pkg::FRAME_CNT_W-1:0] frame_pixels_o,  // accepted last frame
  output logic [cam_pkg::FRAME_CNT_W-1:0] frame_drops_o    // dropped last frame
);
  import cam_pkg::*;

  logic                   vsync_q;    // registered vsync sample
  logic                   vsync_qq;   // previous sample
  logic                   vs_rise;    // blanking just started
  logic                   acc_inc;    // pixel stored this cycle
  logic [FRAME_CNT_W-1:0] pix_cnt;    // running accepted count
  logic [FRAME_CNT_W-1:0] drop_cnt;   // running dropped count

  assign vs_rise = vsync_q & ~vsync_qq;
  assign acc_inc = pix_i.pix_valid & ~drop_i;

  //======================================================================
  // counters, latched and restarted on vsync rise
  //======================================================================
  always_ff @(posedge cmos_pclk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      vsync_q        <= 1'b1;  // assume blanking, no report out of reset
      vsync_qq       <= 1'b1;
      pix_cnt        <= '0;
      drop_cnt       <= '0;
      frame_done_o   <= 1'b0;
      frame_pixels_o <= '0;
      frame_drops_o  <= '0;
    end else begin
      vsync_q      <= vsync_i;
      vsync_qq     <= vsync_q;
      frame_done_o <= vs_rise;
      if (vs_rise) begin
        frame_pixels_o <= pix_cnt + FRAME_CNT_W'(acc_inc);  // include this cycle
        frame_drops_o  <= drop_cnt + FRAME_CNT_W'(drop_i);
        pix_cnt        <= '0;
        drop_cnt       <= '0;
      end else begin
        pix_cnt  <= pix_cnt + FRAME_CNT_W'(acc_inc);
        drop_cnt <= drop_cnt + FRAME_CNT_W'(drop_i);
      end
    end
  end

endmodule

//--- rtl/cam_capture_top.sv
module cam_capture_top (
  input  logic                            cmos_pclk,       // camera pixel clock
  input  logic                            I_rst_n,         // async reset, active low
  input  logic                            cmos_vsync_i,    // high = frame blanking
  input  logic                            cmos_href_i,     // byte valid
  input  cam_pkg::cam_byte_t              cmos_db_i,       // camera data byte
  input  logic                            rd_en_i,         // fifo read strobe
  output logic                            rd_valid_o,      // read data valid
  output logic [15:0]                     rd_data_o,       // reordered RGB565
  output logic                            rd_sof_o,        // first pixel of frame
  output logic                            rd_eol_o,        // last pixel of line
  output logic                            empty_o,         // fifo empty
  output logic                            frame_done_o,    // per-frame report strobe
  output logic [cam_pkg::FRAME_CNT_W-1:0] frame_pixels_o,  // accepted pixels
  output logic [cam_pkg::FRAME_CNT_W-1:0] frame_drops_o    // dropped pixels
);
  import cam_pkg::*;

  pix_stream_if pix_if ();  // assembler -> fifo, monitor

  pix_word_t rd_word;  // fifo output entry
  logic      drop;     // fifo refused a pixel

  //======================================================================
  // camera bytes to pixels
  //======================================================================
  cam_pixel_assembler cam_pixel_assembler_i (
    .cmos_pclk (cmos_pclk),
    .I_rst_n   (I_rst_n),
    .vsync_i   (cmos_vsync_i),
    .href_i    (cmos_href_i),
    .db_i      (cmos_db_i),
    .pix_o     (pix_if.source)
  );

  cam_pixel_fifo cam_pixel_fifo_i (
    .cmos_pclk  (cmos_pclk),
    .I_rst_n    (I_rst_n),
    .pix_i      (pix_if.sink),
    .drop_o     (drop),
    .rd_en_i    (rd_en_i),
    .rd_valid_o (rd_valid_o),
    .rd_word_o  (rd_word),
    .empty_o    (empty_o)
  );

  cam_frame_monitor cam_frame_monitor_i (
    .cmos_pclk      (cmos_pclk),
    .I_rst_n        (I_rst_n),
    .vsync_i        (cmos_vsync_i),
    .pix_i          (pix_if.monitor),
    .drop_i         (drop),
    .frame_done_o   (frame_done_o),
    .frame_pixels_o (frame_pixels_o),
    .frame_drops_o  (frame_drops_o)
  );

  // split the fifo entry
  assign rd_data_o = rd_word.pixel;  // {r,g,b}
  assign rd_sof_o  = rd_word.sof;
  assign rd_eol_o  = rd_word.eol;

endmodule

//--- testbench/cam_fifo_checker.sv
module cam_fifo_checker (
  input logic                        cmos_pclk,   // fifo clock
  input logic                        I_rst_n,     // async reset, active low
  input logic                        rd_en_i,     // read strobe
  input logic                        empty_i,     // fifo empty
  input logic                        rd_valid_i,  // read data valid
  input logic [cam_pkg::FIFO_AW-1:0] wr_ptr_i,    // next slot to write
  input logic [cam_pkg::FIFO_AW:0]   fill_cnt_i   // occupancy
);
  timeunit 1ns;
  timeprecision 1ps;
  import cam_pkg::*;

  int err_cnt = 0;  // failed assertions so far

  // read data only after a strobe that hit a non-empty fifo
  rd_valid_cause: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    rd_valid_i |-> $past(rd_en_i & ~empty_i))
    else begin
      err_cnt++;
      $error("rd_valid_o without an accepted read strobe");
    end

  fill_in_range: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    fill_cnt_i <= FIFO_DEPTH)
    else begin
      err_cnt++;
      $error("fifo occupancy above its depth");
    end

  // write pointer frozen at almost-full
  no_write_afull: assert property (@(posedge cmos_pclk) disable iff (!I_rst_n)
    (fill_cnt_i >= FIFO_AFULL) |=> (wr_ptr_i == $past(wr_ptr_i)))
    else begin
      err_cnt++;
      $error("fifo write at or above the almost-full level");
    end

endmodule

bind cam_pixel_fifo cam_fifo_checker cam_fifo_checker_i (
  .cmos_pclk  (cmos_pclk),
  .I_rst_n    (I_rst_n),
  .rd_en_i    (rd_en_i),
  .empty_i    (empty_o),
  .rd_valid_i (rd_valid_o),
  .wr_ptr_i   (wr_ptr),
  .fill_cnt_i (fill_cnt)
);

//--- testbench/tb_cam_capture.sv
module tb_cam_capture;
  timeunit 1ns;
  timeprecision 1ps;
  import cam_pkg::*;

  localparam int WAIT_CYCLES = 64;  // limit for each wait loop

  logic                   cmos_pclk;
  logic                   I_rst_n;
  logic                   cmos_vsync_i;
  logic                   cmos_href_i;
  cam_byte_t              cmos_db_i;
  logic                   rd_en_i;
  logic                   rd_valid_o;
  logic [15:0]            rd_data_o;
  logic                   rd_sof_o;
  logic                   rd_eol_o;
  logic                   empty_o;
  logic                   frame_done_o;
  logic [FRAME_CNT_W-1:0] frame_pixels_o;
  logic [FRAME_CNT_W-1:0] frame_drops_o;

  logic      cur_vs;        // values the DUT samples at the next edge
  logic      cur_hr;
  cam_byte_t cur_db;
  logic      cur_rd;
  logic      m_phase;       // model: next byte closes a pair
  cam_byte_t m_hi;          // model: first byte of the open pair
  logic      m_sof_pend;    // model: next pixel opens a frame
  logic      m_pv;          // model: pixel at the fifo input
  rgb565_t   m_pix;
  logic      m_sof;
  pix_word_t m_fifo[$];     // model: expected fifo contents
  logic      m_vs_q;        // model: vsync at the last edge
  logic      m_vs_qq;
  int        m_acc;         // accepted so far this frame
  int        m_drop;        // dropped so far this frame
  logic      exp_rd_valid;
  pix_word_t exp_word;
  logic      exp_done;
  int        exp_pix;
  int        exp_drops;

  cam_capture_top cam_capture_top_i (.*);

  initial begin
    cmos_pclk = 1'b0;
    forever #10 cmos_pclk = ~cmos_pclk;  // 50 MHz
  end

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  always @(cam_capture_top_i.cam_pixel_fifo_i.cam_fifo_checker_i.err_cnt) begin
    if (cam_capture_top_i.cam_pixel_fifo_i.cam_fifo_checker_i.err_cnt != 0) begin
      abort_run("a fifo checker assertion failed");
    end
  end

  // raw {first, second} byte: low five to top, middle six kept, top five to bottom
  function automatic rgb565_t reorder(input logic [15:0] raw);
    return {raw[4:0], raw[10:5], raw[15:11]};
  endfunction

  //====================================================================
  // reference model, one call per active clock edge
  //====================================================================
  function automatic void model_step();
    logic      pair;
    logic      wr_ok;
    logic      rd_ok;
    logic      rise;
    pix_word_t w;
    rd_ok = cur_rd && (m_fifo.size() > 0);              // strobe on empty ignored
    wr_ok = m_pv && (m_fifo.size() < FIFO_AFULL);       // almost-full gate
    exp_rd_valid = rd_ok;
    if (rd_ok) exp_word = m_fifo.pop_front();
    if (wr_ok) begin
      w.pixel = m_pix;
      w.sof   = m_sof;
      w.eol   = !cur_hr;                                 // href already low
      m_fifo.push_back(w);
    end
    if (wr_ok) m_acc++;
    else if (m_pv) m_drop++;
    rise     = m_vs_q && !m_vs_qq;                       // blanking began
    exp_done = rise;
    if (rise) begin
      exp_pix   = m_acc;
      exp_drops = m_drop;
      m_acc     = 0;
      m_drop    = 0;
    end
    m_vs_qq = m_vs_q;
    m_vs_q  = cur_vs;
    pair = cur_hr && m_phase;                            // second byte of a pair
    if (pair) begin
      m_pix = reorder({m_hi, cur_db});
      m_sof = m_sof_pend;
    end
    m_pv = pair;
    if (cur_hr && !m_phase) m_hi = cur_db;
    m_phase = cur_hr ? !m_phase : 1'b0;                  // href low restarts pairing
    if (cur_vs) m_sof_pend = 1'b1;
    else if (pair) m_sof_pend = 1'b0;
  endfunction

  task automatic check_outputs();
    assert (rd_valid_o === exp_rd_valid)
      else report_mismatch($sformatf("rd_valid_o is %b, expected %b", rd_valid_o, exp_rd_valid));
    if (exp_rd_valid) begin
      assert (rd_data_o === exp_word.pixel)
        else report_mismatch($sformatf("rd_data_o is %h, expected %h",
                                       rd_data_o, exp_word.pixel));
      assert (rd_sof_o === exp_word.sof)
        else report_mismatch($sformatf("rd_sof_o is %b, expected %b", rd_sof_o, exp_word.sof));
      assert (rd_eol_o === exp_word.eol)
        else report_mismatch($sformatf("rd_eol_o is %b, expected %b", rd_eol_o, exp_word.eol));
    end
    assert (empty_o === (m_fifo.size() == 0))
      else report_mismatch($sformatf("empty_o is %b with %0d entries expected",
                                     empty_o, m_fifo.size()));
    assert (frame_done_o === exp_done)
      else report_mismatch($sformatf("frame_done_o is %b, expected %b", frame_done_o, exp_done));
    if (exp_done) begin
      assert (frame_pixels_o === FRAME_CNT_W'(exp_pix))
        else report_mismatch($sformatf("frame_pixels_o is %0d, model has %0d",
                                       frame_pixels_o, exp_pix));
      assert (frame_drops_o === FRAME_CNT_W'(exp_drops))
        else report_mismatch($sformatf("frame_drops_o is %0d, model has %0d",
                                       frame_drops_o, exp_drops));
    end
  endtask

  // drive at the rising edge, check at the falling edge
  task automatic tick(input logic vs, input logic hr, input cam_byte_t db, input logic rd);
    @(posedge cmos_pclk);
    model_step();
    cmos_vsync_i <= vs;
    cmos_href_i  <= hr;
    cmos_db_i    <= db;
    rd_en_i      <= rd;
    cur_vs = vs;
    cur_hr = hr;
    cur_db = db;
    cur_rd = rd;
    @(negedge cmos_pclk);
    check_outputs();
  endtask

  task automatic wait_frame_report(input int pixels, input int drops);
    int waited;
    waited = 0;
    tick(cur_vs, 1'b0, 8'h00, 1'b0);
    while (!frame_done_o && waited < WAIT_CYCLES) begin
      tick(cur_vs, 1'b0, 8'h00, 1'b0);
      waited++;
    end
    if (!frame_done_o) abort_run("timeout while waiting for frame_done_o");
    assert (frame_pixels_o === FRAME_CNT_W'(pixels))
      else report_mismatch($sformatf("frame_pixels_o is %0d, stimulus expects %0d",
                                     frame_pixels_o, pixels));
    assert (frame_drops_o === FRAME_CNT_W'(drops))
      else report_mismatch($sformatf("frame_drops_o is %0d, stimulus expects %0d",
                                     frame_drops_o, drops));
  endtask

  task automatic drain_fifo(input int reads);
    int got;
    int waited;
    got = 0;
    while (!empty_o && got < FIFO_DEPTH) begin  // at most one full fifo
      tick(cur_vs, 1'b0, 8'h00, 1'b1);    // one read strobe
      waited = 0;
      tick(cur_vs, 1'b0, 8'h00, 1'b0);
      while (!rd_valid_o && waited < WAIT_CYCLES) begin
        tick(cur_vs, 1'b0, 8'h00, 1'b0);
        waited++;
      end
      if (!rd_valid_o) abort_run("timeout while waiting for rd_valid_o");
      got++;
    end
    assert (got == reads)
      else report_mismatch($sformatf("drained %0d pixels, expected %0d", got, reads));
    assert (empty_o === 1'b1) else report_mismatch("empty_o low after the drain");
  endtask

  //====================================================================
  // reset, then stimulus lines in order
  //====================================================================
  initial begin
    string     line;
    int        fd;
    int        n;
    int        cnt;
    int        vs;
    int        hr;
    int        rd;
    int        pix_exp;
    int        drop_exp;
    cam_byte_t db;
    I_rst_n      = 1'b0;
    cmos_vsync_i = 1'b1;             // start in blanking
    cmos_href_i  = 1'b0;
    cmos_db_i    = 8'h00;
    rd_en_i      = 1'b0;
    cur_vs       = 1'b1;
    cur_hr       = 1'b0;
    cur_db       = 8'h00;
    cur_rd       = 1'b0;
    m_phase      = 1'b0;
    m_hi         = 8'h00;
    m_sof_pend   = 1'b0;
    m_pv         = 1'b0;
    m_vs_q       = 1'b1;             // reset counts as blanking
    m_vs_qq      = 1'b1;
    m_acc        = 0;
    m_drop       = 0;
    exp_rd_valid = 1'b0;
    exp_done     = 1'b0;
    fd = $fopen("testbench/cam_stim.txt", "r");
    if (fd == 0) abort_run("cannot open testbench/cam_stim.txt");
    repeat (2) @(posedge cmos_pclk);
    I_rst_n <= 1'b1;
    @(negedge cmos_pclk);
    assert (rd_valid_o === 1'b0 && frame_done_o === 1'b0 && empty_o === 1'b1)
      else report_mismatch("outputs not idle after reset");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      case (line[0])
        "S": begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %h %d", cnt, vs, hr, db, rd);
          if (n != 5) abort_run({"malformed stimulus line: ", line});
          repeat (cnt) begin
            tick(vs[0], hr[0], db, rd[0]);
            db = db + 8'h35;          // next byte of the segment
          end
        end
        "W": begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d", pix_exp, drop_exp);
          if (n != 2) abort_run({"malformed stimulus line: ", line});
          wait_frame_report(pix_exp, drop_exp);
        end
        "D": begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d", cnt);
          if (n != 1) abort_run({"malformed stimulus line: ", line});
          drain_fifo(cnt);
        end
        default: abort_run({"unknown stimulus line: ", line});
      endcase
    end
    $fclose(fd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- testbench/cam_stim.txt
# S cycles vsync href byte0 rd_en : held for cycles, byte0 grows by 8'h35 each cycle
# W pixels drops : wait for frame_done_o with these totals ; D reads : drain the FIFO
# frame 1, reads on, even and odd lines
S 3 1 0 00 0
S 2 0 0 00 1
S 8 0 1 a7 1
S 2 0 0 00 1
S 7 0 1 3c 1
S 2 0 0 00 1
S 6 0 1 f1 1
S 3 0 0 00 1
S 1 1 0 00 0
W 10 0
# frame 2, reads off, one long line overflows the FIFO
S 2 1 0 00 0
S 2 0 0 00 0
S 40 0 1 5e 0
S 2 0 0 00 0
S 1 1 0 00 0
W 14 6
D 14
# frame 3, short gap between lines, odd second line
S 2 1 0 00 0
S 1 0 0 00 1
S 10 0 1 09 1
S 1 0 0 00 1
S 5 0 1 c2 1
S 3 0 0 00 1
S 1 1 0 00 0
W 7 0
D 0

//--- list.f
rtl/cam_pkg.sv
rtl/pix_stream_if.sv
rtl/cam_pixel_assembler.sv
rtl/cam_pixel_fifo.sv
rtl/cam_frame_monitor.sv
rtl/cam_capture_top.sv
testbench/cam_fifo_checker.sv
testbench/tb_cam_capture.sv

//--- Makefile
TOP      := tb_cam_capture
RTL_SRCS := $(shell grep '^rtl/' list.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall $(RTL_SRCS) --top-module cam_capture_top

clean:
	rm -rf obj_dir sim.log
